//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_fetch_mux_stage
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIMFLAGS ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG) || ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/branch_target_unit.sv
`timescale 1ns/1ps

module branch_target_unit (
	input  logic stomp_mux_i,
	slot_if.dst slots,
	output logic do_bsr_o,
	output fetch_pkg::pc_t bsr_tgt_o
);

	import fetch_pkg::*;

	// Displacement field starts above the opcode and register fields
	localparam int DISP_LSB = 10;

	slot_mask_t is_bsr;
	slot_mask_t is_jsr;
	pc_t [SLOTS-1:0] disp;
	pc_t [SLOTS-1:0] slot_tgt;

	// Per-slot decode and target
	always_comb begin
		for (int k = 0; k < SLOTS; k++) begin
			is_bsr[k] = (slots.ins[k][$bits(opcode_t)-1:0] == OP_BSR);
			is_jsr[k] = (slots.ins[k][$bits(opcode_t)-1:0] == OP_JSR);
			disp[k] = pc_t'($signed(slots.ins[k][$bits(insn_t)-1:DISP_LSB]));
			// JSR is absolute, BSR is relative to its own PC
			slot_tgt[k] = is_jsr[k] ? disp[k] : slots.pc[k] + disp[k];
		end
	end

	// Walk from the top slot down so the lowest call ends up selected
	always_comb begin
		bsr_tgt_o = RESET_PC;
		for (int k = SLOTS - 1; k >= 0; k--) begin
			if (is_bsr[k] || is_jsr[k]) begin
				bsr_tgt_o = slot_tgt[k];
			end
		end
	end

	assign do_bsr_o = (|(is_bsr | is_jsr)) && !stomp_mux_i;

endmodule

//--- design/fetch_ifs.sv
`timescale 1ns/1ps

// Fetched line with its PC, passed from the fetch register to the extractor
interface fetch_if;
	import fetch_pkg::*;

	line_t line;
	pc_t pc;
	// Branch-miss PC captured alongside the line
	pc_t misspc;

	modport src (output line, pc, misspc);
	modport dst (input line, pc, misspc);
endinterface

// Registered group of four instruction slots
interface slot_if;
	import fetch_pkg::*;

	insn_t [SLOTS-1:0] ins;
	pc_t [SLOTS-1:0] pc;
	logic valid;
	logic hwi;
	slot_mask_t slot_nop;

	modport src (output ins, pc, valid, hwi, slot_nop);
	// The branch unit only looks at the words and their PCs
	modport dst (input ins, pc);
endinterface

//--- design/fetch_mux_stage.sv
`timescale 1ns/1ps

module fetch_mux_stage #(
	parameter int STARTUP_CYCLES = 4
) (
	input  logic clk,
	input  logic rst_i,
	input  logic advance_i,
	input  logic en_i,
	input  logic ihit_i,
	input  fetch_pkg::pc_t pc_i,
	input  fetch_pkg::line_t line_i,
	input  logic irq_i,
	input  logic nmi_i,
	input  logic branchmiss_i,
	input  fetch_pkg::pc_t misspc_i,
	input  logic stomp_mux_i,
	output fetch_pkg::insn_t [fetch_pkg::SLOTS-1:0] ins_o,
	output fetch_pkg::pc_t [fetch_pkg::SLOTS-1:0] pc_o,
	output logic valid_o,
	output logic hwi_o,
	output fetch_pkg::slot_mask_t slot_nop_o,
	output logic nop_o,
	output logic do_bsr_o,
	output fetch_pkg::pc_t bsr_tgt_o
);

	logic ready;

	fetch_if fetch_bus ();
	slot_if slot_bus ();

	// ====================
	// Fetch side
	// ====================

	startup_counter #(
		.STARTUP_CYCLES(STARTUP_CYCLES)
	) i_startup_counter (
		.clk(clk),
		.rst_i(rst_i),
		.ready_o(ready)
	);

	fetch_register i_fetch_register (
		.clk(clk),
		.rst_i(rst_i),
		.ready_i(ready),
		.advance_i(advance_i),
		.en_i(en_i),
		.ihit_i(ihit_i),
		.pc_i(pc_i),
		.line_i(line_i),
		.misspc_i(misspc_i),
		.fetch(fetch_bus.src)
	);

	// ====================
	// Slot side
	// ====================

	slot_extractor i_slot_extractor (
		.clk(clk),
		.rst_i(rst_i),
		.en_i(en_i),
		.irq_i(irq_i),
		.nmi_i(nmi_i),
		.branchmiss_i(branchmiss_i),
		.fetch(fetch_bus.dst),
		.slots(slot_bus.src)
	);

	branch_target_unit i_branch_target_unit (
		.stomp_mux_i(stomp_mux_i),
		.slots(slot_bus.dst),
		.do_bsr_o(do_bsr_o),
		.bsr_tgt_o(bsr_tgt_o)
	);

	assign ins_o = slot_bus.ins;
	assign pc_o = slot_bus.pc;
	assign valid_o = slot_bus.valid;
	assign hwi_o = slot_bus.hwi;
	assign slot_nop_o = slot_bus.slot_nop;

	// Stomp flag travels with the slot group, one enable behind
	always_ff @(posedge clk) begin
		if (rst_i) begin
			nop_o <= 1'b0;
		end else if (en_i) begin
			nop_o <= stomp_mux_i;
		end
	end

endmodule

//--- design/fetch_pkg.sv
package fetch_pkg;

	// ====================
	// Widths
	// ====================

	// Byte address of an instruction
	typedef logic [31:0] pc_t;
	typedef logic [63:0] insn_t;
	// A cache line holds eight instruction words
	typedef logic [511:0] line_t;
	typedef logic [6:0] opcode_t;

	localparam int SLOTS = 4;
	localparam int INSN_BYTES = 8;
	localparam int LINE_WORDS = $bits(line_t) / $bits(insn_t);

	// One bit per slot of a group
	typedef logic [SLOTS-1:0] slot_mask_t;

	// ====================
	// Encodings
	// ====================

	localparam opcode_t OP_NOP = 7'h0B;
	localparam opcode_t OP_BSR = 7'h20;
	localparam opcode_t OP_JSR = 7'h21;

	// Filler word for missed lines, start-up and alignment padding
	localparam insn_t NOP_INSN = {{($bits(insn_t) - $bits(opcode_t)){1'b0}}, OP_NOP};

	localparam pc_t RESET_PC = 32'hFFFD_0000;

endpackage

//--- design/fetch_register.sv
`timescale 1ns/1ps

module fetch_register (
	input  logic clk,
	input  logic rst_i,
	input  logic ready_i,
	input  logic advance_i,
	input  logic en_i,
	input  logic ihit_i,
	input  fetch_pkg::pc_t pc_i,
	input  fetch_pkg::line_t line_i,
	input  fetch_pkg::pc_t misspc_i,
	fetch_if.src fetch
);

	import fetch_pkg::*;

	localparam line_t NOP_LINE = {LINE_WORDS{NOP_INSN}};

	line_t line_q;
	pc_t pc_q;
	pc_t misspc_q;

	// ====================
	// Line and fetch PC
	// ====================

	// A miss or a line fetched before the caches settle turns into NOPs
	always_ff @(posedge clk) begin
		if (rst_i) begin
			line_q <= NOP_LINE;
			pc_q <= RESET_PC;
		end else if (advance_i) begin
			line_q <= (ihit_i && ready_i) ? line_i : NOP_LINE;
			pc_q <= pc_i;
		end
	end

	// The miss PC follows the downstream enable, not fetch
	always_ff @(posedge clk) begin
		if (rst_i) begin
			misspc_q <= RESET_PC;
		end else if (en_i) begin
			misspc_q <= misspc_i;
		end
	end

	assign fetch.line = line_q;
	assign fetch.pc = pc_q;
	assign fetch.misspc = misspc_q;

endmodule

//--- design/slot_extractor.sv
`timescale 1ns/1ps

module slot_extractor (
	input  logic clk,
	input  logic rst_i,
	input  logic en_i,
	input  logic irq_i,
	input  logic nmi_i,
	input  logic branchmiss_i,
	fetch_if.dst fetch,
	slot_if.src slots
);

	import fetch_pkg::*;

	// PC bits that select the word inside the line
	localparam int WORD_LSB = $clog2(INSN_BYTES);
	localparam int WORD_BITS = $clog2(LINE_WORDS);
	localparam int INSN_SHIFT = $clog2($bits(insn_t));
	localparam int ALIGN_W = SLOTS * $bits(insn_t);

	logic [WORD_BITS+INSN_SHIFT-1:0] shift_amt;
	logic [$bits(line_t)+ALIGN_W-1:0] shifted;
	insn_t [SLOTS-1:0] slot_ins;
	pc_t [SLOTS-1:0] slot_pc;
	slot_mask_t miss_nop;
	logic hw_int;

	insn_t [SLOTS-1:0] ins_q;
	pc_t [SLOTS-1:0] pc_q;
	logic valid_q;
	logic hwi_q;
	slot_mask_t slot_nop_q;

	// ====================
	// Alignment
	// ====================

	assign shift_amt = {fetch.pc[WORD_LSB+WORD_BITS-1:WORD_LSB], {INSN_SHIFT{1'b0}}};

	// Words past the end of the line come in as NOPs from the padding
	always_comb begin
		shifted = {{SLOTS{NOP_INSN}}, fetch.line} >> shift_amt;
		for (int k = 0; k < SLOTS; k++) begin
			slot_ins[k] = shifted[k*$bits(insn_t) +: $bits(insn_t)];
			slot_pc[k] = fetch.pc + pc_t'(k * INSN_BYTES);
			// Anything before the miss target must not execute
			miss_nop[k] = branchmiss_i && (fetch.misspc > slot_pc[k]);
		end
	end

	// An interrupt in progress voids the whole group
	assign hw_int = irq_i | nmi_i;

	// ====================
	// Slot registers
	// ====================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int k = 0; k < SLOTS; k++) begin
				ins_q[k] <= NOP_INSN;
				pc_q[k] <= RESET_PC + pc_t'(k * INSN_BYTES);
			end
			valid_q <= 1'b0;
			hwi_q <= 1'b0;
			slot_nop_q <= '0;
		end else if (en_i) begin
			ins_q <= slot_ins;
			pc_q <= slot_pc;
			valid_q <= ~hw_int;
			hwi_q <= hw_int;
			slot_nop_q <= miss_nop;
		end
	end

	assign slots.ins = ins_q;
	assign slots.pc = pc_q;
	assign slots.valid = valid_q;
	assign slots.hwi = hwi_q;
	assign slots.slot_nop = slot_nop_q;

endmodule

//--- design/startup_counter.sv
`timescale 1ns/1ps

module startup_counter #(
	parameter int STARTUP_CYCLES = 4
) (
	input  logic clk,
	input  logic rst_i,
	output logic ready_o
);

	// Wide enough to hold STARTUP_CYCLES, never zero bits
	localparam int CW = $clog2(STARTUP_CYCLES + 2);

	logic [CW-1:0] count;

	// Counts up after reset and sticks at the end of the window
	always_ff @(posedge clk) begin
		if (rst_i) begin
			count <= '0;
		end else if (count != CW'(STARTUP_CYCLES)) begin
			count <= count + 1'b1;
		end
	end

	assign ready_o = (count == CW'(STARTUP_CYCLES));

endmodule

//--- tb.f
design/fetch_pkg.sv
design/fetch_ifs.sv
design/startup_counter.sv
design/fetch_register.sv
design/slot_extractor.sv
design/branch_target_unit.sv
design/fetch_mux_stage.sv
testbench/fetch_mux_stage_props.sv
testbench/tb_fetch_mux_stage.sv

//--- testbench/fetch_mux_stage_props.sv
`timescale 1ns/1ps

module fetch_mux_stage_props (
	input logic clk,
	input logic rst_i,
	input logic en_i,
	input logic irq_i,
	input logic nmi_i,
	input logic stomp_i,
	input fetch_pkg::insn_t [fetch_pkg::SLOTS-1:0] ins_i,
	input fetch_pkg::pc_t [fetch_pkg::SLOTS-1:0] slot_pc_i,
	input logic valid_i,
	input logic hwi_i,
	input fetch_pkg::slot_mask_t slot_nop_i,
	input logic nop_i,
	input logic do_bsr_i
);

	int fail_count = 0;

	// Outputs are quiet in the first cycle after reset
	a_reset_quiet: assert property (@(posedge clk) $fell(rst_i) |->
		!valid_i && !hwi_i && slot_nop_i == '0 && !nop_i && !do_bsr_i)
	else begin
		$error("outputs active in the first cycle after reset");
		fail_count++;
	end

	// An interrupt voids the group registered at the same edge
	a_interrupt: assert property (@(posedge clk) disable iff (rst_i) en_i |=>
		hwi_i == $past(irq_i || nmi_i) && valid_i == !$past(irq_i || nmi_i))
	else begin
		$error("valid_o or hwi_o does not follow irq_i and nmi_i");
		fail_count++;
	end

	// The stomp flag lags stomp_mux_i by one enabled edge
	a_stomp_delay: assert property (@(posedge clk) disable iff (rst_i) en_i |=>
		nop_i == $past(stomp_i))
	else begin
		$error("nop_o does not follow stomp_mux_i from the previous enabled edge");
		fail_count++;
	end

	// ====================
	// Back-pressure
	// ====================

	a_hold: assert property (@(posedge clk) disable iff (rst_i) !en_i |=>
		$stable(ins_i) && $stable(slot_pc_i) && $stable(valid_i) && $stable(nop_i))
	else begin
		$error("slot outputs changed while en_i was low");
		fail_count++;
	end

endmodule

//--- testbench/tb_fetch_mux_stage.sv
`timescale 1ns/1ps

module tb_fetch_mux_stage;

	import fetch_pkg::*;

	localparam int STARTUP = 4;
	localparam int RUN_CYCLES = 3000;
	localparam int VALID_TIMEOUT = 40;
	localparam pc_t PC_BASE = 32'h0000_1000;
	localparam line_t NOP_LINE = {LINE_WORDS{NOP_INSN}};

	logic clk = 1'b0;
	logic rst_i, advance_i, en_i, ihit_i, irq_i, nmi_i, branchmiss_i, stomp_mux_i;
	pc_t pc_i, misspc_i, bsr_tgt_o;
	line_t line_i;
	insn_t [SLOTS-1:0] ins_o;
	pc_t [SLOTS-1:0] pc_o;
	logic valid_o, hwi_o, nop_o, do_bsr_o;
	slot_mask_t slot_nop_o;

	// Expected state of the stage, rebuilt every clock
	line_t m_line;
	pc_t m_pc, m_misspc;
	int m_count;
	insn_t [SLOTS-1:0] exp_ins;
	pc_t [SLOTS-1:0] exp_pc;
	logic exp_valid, exp_hwi, exp_nop;
	slot_mask_t exp_slot_nop;
	int errors = 0;
	int timeouts = 0;

	fetch_mux_stage #(.STARTUP_CYCLES(STARTUP)) i_fetch_mux_stage (.*);

	bind fetch_mux_stage fetch_mux_stage_props i_fetch_mux_stage_props (
		.clk(clk), .rst_i(rst_i), .en_i(en_i), .irq_i(irq_i), .nmi_i(nmi_i),
		.stomp_i(stomp_mux_i), .ins_i(ins_o), .slot_pc_i(pc_o), .valid_i(valid_o),
		.hwi_i(hwi_o), .slot_nop_i(slot_nop_o), .nop_i(nop_o), .do_bsr_i(do_bsr_o)
	);

	always #4 clk = ~clk;

	// ====================
	// Stimulus
	// ====================

	function automatic insn_t random_word();
		insn_t w;
		w = {$urandom, $urandom};
		case ($urandom % 4)
			0: w[6:0] = OP_BSR;
			1: w[6:0] = OP_JSR;
			default: ;
		endcase
		return w;
	endfunction

	task automatic drive_random();
		line_t new_line;
		for (int w = 0; w < LINE_WORDS; w++) begin
			new_line[w*64 +: 64] = random_word();
		end
		line_i <= new_line;
		pc_i <= PC_BASE + pc_t'(($urandom % 64) * INSN_BYTES);
		// Miss PCs land around the fetch window so slot_nop_o gets partial masks
		misspc_i <= PC_BASE + pc_t'(($urandom % 72) * INSN_BYTES);
		advance_i <= ($urandom % 8) != 0;
		en_i <= ($urandom % 6) != 0;
		ihit_i <= ($urandom % 4) != 0;
		irq_i <= ($urandom % 8) == 0;
		nmi_i <= ($urandom % 16) == 0;
		branchmiss_i <= ($urandom % 3) == 0;
		stomp_mux_i <= ($urandom % 4) == 0;
	endtask

	// ====================
	// Model
	// ====================

	// The slot group reads the fetch state from before this edge
	task automatic step_model();
		int idx;
		if (en_i) begin
			for (int k = 0; k < SLOTS; k++) begin
				idx = int'((m_pc / INSN_BYTES) % LINE_WORDS) + k;
				exp_ins[k] = (idx < LINE_WORDS) ? m_line[idx*64 +: 64] : NOP_INSN;
				exp_pc[k] = m_pc + pc_t'(k * INSN_BYTES);
				exp_slot_nop[k] = branchmiss_i && (m_misspc > exp_pc[k]);
			end
			exp_valid = !(irq_i || nmi_i);
			exp_hwi = irq_i || nmi_i;
			exp_nop = stomp_mux_i;
			m_misspc = misspc_i;
		end
		if (advance_i) begin
			m_line = (ihit_i && m_count >= STARTUP) ? line_i : NOP_LINE;
			m_pc = pc_i;
		end
		if (m_count < STARTUP) begin
			m_count++;
		end
	endtask

	always @(posedge clk) begin
		if (rst_i) begin
			m_line = NOP_LINE;
			m_pc = RESET_PC;
			m_misspc = RESET_PC;
			m_count = 0;
			for (int k = 0; k < SLOTS; k++) begin
				exp_ins[k] = NOP_INSN;
				exp_pc[k] = RESET_PC + pc_t'(k * INSN_BYTES);
			end
			{exp_valid, exp_hwi, exp_nop} = '0;
			exp_slot_nop = '0;
		end else begin
			step_model();
		end
	end

	// ====================
	// Checks
	// ====================

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_outputs();
		logic found;
		pc_t tgt;
		found = 1'b0;
		tgt = RESET_PC;
		for (int k = 0; k < SLOTS; k++) begin
			if (!found && (exp_ins[k][6:0] == OP_BSR || exp_ins[k][6:0] == OP_JSR)) begin
				found = 1'b1;
				// Bits 41 to 10 are what is left of the sign-extended displacement
				tgt = exp_ins[k][41:10];
				if (exp_ins[k][6:0] == OP_BSR) begin
					tgt = tgt + exp_pc[k];
				end
			end
			compare_value($sformatf("ins_o[%0d]", k), ins_o[k], exp_ins[k]);
			compare_value($sformatf("pc_o[%0d]", k), 64'(pc_o[k]), 64'(exp_pc[k]));
		end
		compare_value("valid_o", 64'(valid_o), 64'(exp_valid));
		compare_value("hwi_o", 64'(hwi_o), 64'(exp_hwi));
		compare_value("slot_nop_o", 64'(slot_nop_o), 64'(exp_slot_nop));
		compare_value("nop_o", 64'(nop_o), 64'(exp_nop));
		compare_value("do_bsr_o", 64'(do_bsr_o), 64'(found && !stomp_mux_i));
		compare_value("bsr_tgt_o", 64'(bsr_tgt_o), 64'(tgt));
	endtask

	always @(negedge clk) begin
		if (!rst_i) begin
			check_outputs();
		end
	end

	initial begin
		int waited;
		void'($urandom(64));
		rst_i = 1'b1;
		{advance_i, en_i, ihit_i, irq_i, nmi_i, branchmiss_i, stomp_mux_i} = '0;
		pc_i = '0;
		misspc_i = '0;
		line_i = '0;
		repeat (16) @(posedge clk);
		rst_i <= 1'b0;
		waited = 0;
		while (valid_o !== 1'b1 && waited < VALID_TIMEOUT) begin
			@(posedge clk);
			drive_random();
			@(negedge clk);
			waited++;
		end
		if (valid_o !== 1'b1) begin
			$display("Timeout: no valid group within %0d cycles after reset", VALID_TIMEOUT);
			timeouts++;
		end else begin
			for (int n = 0; n < RUN_CYCLES; n++) begin
				@(posedge clk);
				drive_random();
			end
			@(negedge clk);
		end
		$display("Errors: %0d mismatches, %0d assertion failures, %0d timeouts", errors,
			i_fetch_mux_stage.i_fetch_mux_stage_props.fail_count, timeouts);
		if (errors == 0 && timeouts == 0
			&& i_fetch_mux_stage.i_fetch_mux_stage_props.fail_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
